// ==== apu_pkg.sv ====
`default_nettype none

package apu_pkg;

	typedef logic [3:0] level_t;   // channel level or volume
	typedef logic [7:0] sample_t;  // mixed output
	typedef logic [10:0] timer_t;
	typedef logic [7:0] len_t;
	typedef logic [4:0] reg_addr_t;

	typedef struct packed {
		logic we;
		reg_addr_t addr;
		logic [7:0] data;
	} reg_wr_t;

	typedef struct packed {
		logic quarter;
		logic half;
	} frame_evt_t;

	typedef struct packed {
		logic frame_int;  // read back in bit 6
		logic noise;      // bit 1
		logic pulse;      // bit 0
	} status_t;

	localparam reg_addr_t PULSE_CTRL = 5'd0;
	localparam reg_addr_t PULSE_LO = 5'd2;
	localparam reg_addr_t PULSE_HI = 5'd3;
	localparam reg_addr_t NOISE_CTRL = 5'd12;
	localparam reg_addr_t NOISE_PERIOD = 5'd14;
	localparam reg_addr_t NOISE_LEN = 5'd15;
	localparam reg_addr_t STATUS = 5'd21;
	localparam reg_addr_t FRAME = 5'd23;

	// enable bits at STATUS, same positions as the status read
	localparam int EN_PULSE = 0;
	localparam int EN_NOISE = 1;

	localparam logic [11:0] FRAME_LOAD [5] = '{
		12'd3727, 12'd3727, 12'd3728, 12'd3728, 12'd3725
	};

	localparam len_t LENGTH_TABLE [32] = '{
		8'd10, 8'd254, 8'd20, 8'd2, 8'd40, 8'd4, 8'd80, 8'd6,
		8'd160, 8'd8, 8'd60, 8'd10, 8'd14, 8'd12, 8'd26, 8'd14,
		8'd12, 8'd16, 8'd24, 8'd18, 8'd48, 8'd20, 8'd96, 8'd22,
		8'd192, 8'd24, 8'd72, 8'd26, 8'd16, 8'd28, 8'd32, 8'd30
	};

	// in apu ticks, half the usual cpu cycle counts
	localparam timer_t NOISE_PERIODS [16] = '{
		11'd2, 11'd4, 11'd8, 11'd16, 11'd32, 11'd48, 11'd64, 11'd80,
		11'd101, 11'd127, 11'd190, 11'd254, 11'd381, 11'd508, 11'd1017, 11'd2034
	};

	// bit n is the output at sequencer step n
	localparam logic [7:0] DUTY_TABLE [4] = '{
		8'b0000_0010,  // 12.5%
		8'b0000_0110,  // 25%
		8'b0001_1110,  // 50%
		8'b1111_1001   // 75%
	};

endpackage

`default_nettype wire

// ==== apu_frame.sv ====
`timescale 1ns/100ps
`default_nettype none

module apu_frame (
	input logic sys_clk,
	input logic sys_rst_n,
	input apu_pkg::reg_wr_t wr,
	input logic stat_read,
	output apu_pkg::frame_evt_t evt,
	output logic frame_int
);

	import apu_pkg::*;

	typedef enum logic [2:0] {S0, S1, S2, S3, S4} step_t;

	step_t step, next_step;
	logic [11:0] cnt;
	logic tick;       // apu rate enable
	logic restart;    // frame write waiting for the next tick
	logic mode;       // 1 = 5-step
	logic inhibit;
	logic half_step;
	logic frame_wr;
	logic int_set;

	assign frame_wr = wr.we && wr.addr == FRAME;

	always_comb begin
		next_step = S0;
		half_step = 1'b0;
		case (step)
			S0: next_step = S1;
			S1: begin
				next_step = S2;
				half_step = 1'b1;
			end
			S2: next_step = S3;
			S3: begin
				next_step = mode ? S4 : S0;
				half_step = !mode;
			end
			S4: begin
				next_step = S0;
				half_step = 1'b1;
			end
			default: next_step = S0;
		endcase
	end

	always_ff @(posedge sys_clk, negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			tick <= 1'b0;
			restart <= 1'b0;
			step <= S0;
			cnt <= FRAME_LOAD[0];
			evt <= '0;
		end else begin
			tick <= ~tick;
			evt <= '0;
			if (frame_wr) begin
				restart <= 1'b1;
			end else if (tick && restart) begin
				restart <= 1'b0;
				step <= S0;
				cnt <= FRAME_LOAD[0];
			end else if (tick) begin
				if (cnt == 12'd0) begin
					evt.quarter <= 1'b1;
					evt.half <= half_step;
					step <= next_step;
					cnt <= FRAME_LOAD[next_step];
				end else begin
					cnt <= cnt - 12'd1;
				end
			end
		end
	end

	// end of the last 4-step step
	assign int_set = tick && !restart && cnt == 12'd0 && step == S3 && !mode && !inhibit;

	always_ff @(posedge sys_clk, negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			mode <= 1'b0;
			inhibit <= 1'b0;
			frame_int <= 1'b0;
		end else begin
			if (frame_wr) begin
				mode <= wr.data[7];
				inhibit <= wr.data[6];
			end
			if (int_set)
				frame_int <= 1'b1;
			else if (inhibit || stat_read)
				frame_int <= 1'b0;
		end
	end

	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		evt.quarter |=> !evt.quarter);
	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		evt.half |=> !evt.half);
	// a 4-step sequence never reaches the fifth step once restarted
	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!mode && !restart |-> step != S4);

endmodule

`default_nettype wire

// ==== apu_pulse.sv ====
`timescale 1ns/100ps
`default_nettype none

module apu_pulse (
	input logic sys_clk,
	input logic sys_rst_n,
	input apu_pkg::reg_wr_t wr,
	input logic en,
	input apu_pkg::frame_evt_t evt,
	output apu_pkg::level_t level,
	output logic act
);

	import apu_pkg::*;

	logic tick;
	logic [1:0] duty;
	logic halt;
	level_t vol;
	timer_t period;
	timer_t timer;
	logic [2:0] seq;   // duty step
	len_t len;
	logic hi_wr;

	assign hi_wr = wr.we && wr.addr == PULSE_HI;

	always_ff @(posedge sys_clk, negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			duty <= 2'd0;
			halt <= 1'b0;
			vol <= '0;
			period <= '0;
		end else if (wr.we) begin
			case (wr.addr)
				PULSE_CTRL: begin
					duty <= wr.data[7:6];
					halt <= wr.data[5];
					vol <= wr.data[3:0];
				end
				PULSE_LO: period[7:0] <= wr.data;
				PULSE_HI: period[10:8] <= wr.data[2:0];
				default: ;
			endcase
		end
	end

	always_ff @(posedge sys_clk, negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			tick <= 1'b0;
			timer <= '0;
			seq <= 3'd0;
		end else begin
			tick <= ~tick;
			if (hi_wr)
				seq <= 3'd0;
			else if (tick) begin
				if (timer == '0) begin
					timer <= period;
					seq <= seq + 3'd1;
				end else begin
					timer <= timer - 11'd1;
				end
			end
		end
	end

	always_ff @(posedge sys_clk, negedge sys_rst_n) begin
		if (!sys_rst_n)
			len <= '0;
		else if (!en)
			len <= '0;
		else if (hi_wr)
			len <= LENGTH_TABLE[wr.data[7:3]];
		else if (evt.half && !halt && len != '0)
			len <= len - 8'd1;
	end

	assign act = len != '0;

	// periods below 8 would be ultrasonic, muted
	assign level = (DUTY_TABLE[duty][seq] && act && period >= 11'd8) ? vol : '0;

	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!act |-> level == '0);

endmodule

`default_nettype wire

// ==== apu_noise.sv ====
`timescale 1ns/100ps
`default_nettype none

module apu_noise (
	input logic sys_clk,
	input logic sys_rst_n,
	input apu_pkg::reg_wr_t wr,
	input logic en,
	input apu_pkg::frame_evt_t evt,
	output apu_pkg::level_t level,
	output logic act
);

	import apu_pkg::*;

	logic tick;
	logic halt;
	level_t vol;
	logic mode;          // short sequence
	logic [3:0] pidx;
	timer_t timer;
	logic [14:0] lfsr;
	logic fb;
	len_t len;

	always_ff @(posedge sys_clk, negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			halt <= 1'b0;
			vol <= '0;
			mode <= 1'b0;
			pidx <= 4'd0;
		end else if (wr.we) begin
			case (wr.addr)
				NOISE_CTRL: begin
					halt <= wr.data[5];
					vol <= wr.data[3:0];
				end
				NOISE_PERIOD: begin
					mode <= wr.data[7];
					pidx <= wr.data[3:0];
				end
				default: ;
			endcase
		end
	end

	assign fb = lfsr[0] ^ (mode ? lfsr[6] : lfsr[1]);

	always_ff @(posedge sys_clk, negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			tick <= 1'b0;
			timer <= '0;
			lfsr <= 15'd1;
		end else begin
			tick <= ~tick;
			if (tick) begin
				if (timer == '0) begin
					timer <= NOISE_PERIODS[pidx];
					lfsr <= {fb, lfsr[14:1]};
				end else begin
					timer <= timer - 11'd1;
				end
			end
		end
	end

	always_ff @(posedge sys_clk, negedge sys_rst_n) begin
		if (!sys_rst_n)
			len <= '0;
		else if (!en)
			len <= '0;
		else if (wr.we && wr.addr == NOISE_LEN)
			len <= LENGTH_TABLE[wr.data[7:3]];
		else if (evt.half && !halt && len != '0)
			len <= len - 8'd1;
	end

	assign act = len != '0;
	assign level = (!lfsr[0] && act) ? vol : '0;

	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!act |-> level == '0);

endmodule

`default_nettype wire

// ==== apu_mixer.sv ====
`timescale 1ns/100ps
`default_nettype none

module apu_mixer (
	input logic sys_clk,
	input logic sys_rst_n,
	input apu_pkg::level_t pulse,
	input apu_pkg::level_t noise,
	output apu_pkg::sample_t out
);

	import apu_pkg::*;

	sample_t sum;

	// linear mix, two 4-bit levels
	assign sum = sample_t'(pulse) + sample_t'(noise);

	always_ff @(posedge sys_clk, negedge sys_rst_n) begin
		if (!sys_rst_n)
			out <= '0;
		else
			out <= sum;
	end

	// peak is 15 + 15
	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		out <= sample_t'(30));

endmodule

`default_nettype wire

// ==== apu.sv ====
`timescale 1ns/100ps
`default_nettype none

module apu (
	input logic sys_clk,
	input logic sys_rst_n,
	input logic we,
	input logic re,
	input apu_pkg::reg_addr_t addr,
	input logic [7:0] wdata,
	output logic [7:0] rdata,
	output logic irq,
	output apu_pkg::sample_t out
);

	import apu_pkg::*;

	reg_wr_t wr;
	frame_evt_t evt;
	status_t stat;
	level_t pulse_level, noise_level;
	logic pulse_en, noise_en;
	logic pulse_act, noise_act;
	logic frame_int;
	logic stat_read;

	assign wr.we = we;
	assign wr.addr = addr;
	assign wr.data = wdata;

	always_ff @(posedge sys_clk, negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			pulse_en <= 1'b0;
			noise_en <= 1'b0;
		end else if (we && addr == STATUS) begin
			pulse_en <= wdata[EN_PULSE];
			noise_en <= wdata[EN_NOISE];
		end
	end

	assign stat_read = re && addr == STATUS;

	assign stat.frame_int = frame_int;
	assign stat.noise = noise_act;
	assign stat.pulse = pulse_act;

	assign rdata = stat_read ? {1'b0, stat.frame_int, 4'b0000, stat.noise, stat.pulse} : 8'h00;
	assign irq = frame_int;

	apu_frame frame0 (
		.sys_clk, .sys_rst_n, .wr, .stat_read, .evt, .frame_int
	);

	apu_pulse pulse0 (
		.sys_clk, .sys_rst_n, .wr, .en(pulse_en), .evt,
		.level(pulse_level), .act(pulse_act)
	);

	apu_noise noise0 (
		.sys_clk, .sys_rst_n, .wr, .en(noise_en), .evt,
		.level(noise_level), .act(noise_act)
	);

	apu_mixer mix0 (
		.sys_clk, .sys_rst_n, .pulse(pulse_level), .noise(noise_level), .out
	);

endmodule

`default_nettype wire

// ==== tb_apu.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_apu;

	import apu_pkg::*;

	localparam int SEQ4 = 2 * (3728 + 3728 + 3729 + 3729);  // sys cycles per 4-step sequence
	localparam int MAX_CYCLES = 10 * SEQ4;  // t2 2, t4 1, t5 3, t6 3 sequences plus slack

	logic sys_clk, sys_rst_n, we, re, irq;
	reg_addr_t addr;
	logic [7:0] wdata, rdata, st;
	sample_t out;
	integer seed = 32'hd07d_1b7e;
	int cycle = 0, errors = 0, err_mark = 0, n_pass = 0, n_fail = 0;
	int ref_cyc, fall, idx, len;
	logic [3:0] pv, nv;
	bit seen_p, seen_n;
	reg_addr_t chan_regs [6] = '{PULSE_CTRL, PULSE_LO, PULSE_HI, NOISE_CTRL, NOISE_PERIOD, NOISE_LEN};

	apu dut_i (.sys_clk, .sys_rst_n, .we, .re, .addr, .wdata, .rdata, .irq, .out);

	initial begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk;
	end

	always @(posedge sys_clk) begin
		cycle <= cycle + 1;
		if (cycle >= MAX_CYCLES) begin
			$display("run stopped by timeout after %0d cycles", cycle);
			$display("Test failed");
			$finish;
		end
	end

	function automatic int rnd(input int n);
		return ($random(seed) & 32'h7fff_ffff) % n;
	endfunction

	// sys cycles from a FRAME write to half-frame event n of the 4-step sequence
	function automatic int half_at(input int n);
		return ((n - 1) / 2) * SEQ4 + ((n % 2) ? 2 * 7456 : 2 * 14914);
	endfunction

	task automatic write_reg(input reg_addr_t a, input logic [7:0] d);
		@(negedge sys_clk);
		we = 1'b1;
		addr = a;
		wdata = d;
		@(negedge sys_clk);
		we = 1'b0;
	endtask

	task automatic read_status(output logic [7:0] v);
		@(negedge sys_clk);
		re = 1'b1;
		addr = STATUS;
		#10 v = rdata;
		@(negedge sys_clk);
		re = 1'b0;
	endtask

	task automatic check(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	// poll a status bit until it drops, then compare the cycle with the model
	task automatic expect_fall(input int bitn, input int exp_cyc, input string name);
		fall = -1;
		while (fall < 0 && cycle < exp_cyc + 100) begin
			@(negedge sys_clk);
			re = 1'b1;
			addr = STATUS;
			#10;
			if (!rdata[bitn])
				fall = cycle;
		end
		re = 1'b0;
		if (fall < 0) begin
			$display("%s never went low", name);
			errors++;
		end else if (fall < exp_cyc - 8 || fall > exp_cyc + 8) begin
			$display("%s went low at cycle %0d, expected near %0d", name, fall, exp_cyc);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		if (errors == err_mark) begin
			n_pass++;
			$display("%s: passed", name);
		end else begin
			n_fail++;
			$display("%s: failed with %0d errors", name, errors - err_mark);
		end
		err_mark = errors;
	endtask

	initial begin
		sys_rst_n = 1'b0;
		we = 1'b0;
		re = 1'b0;
		addr = '0;
		wdata = '0;
		repeat (5) @(negedge sys_clk);
		sys_rst_n = 1'b1;

		// 1: quiet after reset, channel writes do nothing while disabled
		read_status(st);
		check("rdata", st, 8'h00);
		check("irq", {7'd0, irq}, 8'h00);
		check("out", out, 8'h00);
		repeat (20) write_reg(chan_regs[rnd(6)], 8'($random(seed)));
		read_status(st);
		check("rdata", st, 8'h00);
		check("out", out, 8'h00);
		end_test("test 1 reset and disabled writes");

		// 2: pulse length runs out after its table count of half frames
		idx = rnd(2) ? 5 : 3;
		len = (idx == 5) ? 4 : 2;
		write_reg(STATUS, 8'h01);
		write_reg(PULSE_CTRL, 8'h8f);  // halt clear
		write_reg(FRAME, 8'h00);
		ref_cyc = cycle;
		write_reg(PULSE_HI, {5'(idx), 3'b001});
		read_status(st);
		check("pulse act", {7'd0, st[0]}, 8'h01);
		expect_fall(0, ref_cyc + half_at(len), "pulse act");
		write_reg(PULSE_HI, {5'd1, 3'b001});
		read_status(st);
		check("pulse act", {7'd0, st[0]}, 8'h01);
		write_reg(STATUS, 8'h00);
		read_status(st);
		check("pulse act", {7'd0, st[0]}, 8'h00);
		end_test("test 2 pulse length");

		// 3: mixed samples come from the two volumes only
		pv = 4'(1 + rnd(15));
		nv = 4'((pv + rnd(14)) % 15 + 1);
		seen_p = 0;
		seen_n = 0;
		write_reg(STATUS, 8'h03);
		write_reg(PULSE_CTRL, {2'(rnd(4)), 2'b10, pv});
		write_reg(PULSE_LO, 8'(8 + rnd(120)));
		write_reg(PULSE_HI, {5'd1, 3'b000});
		write_reg(NOISE_CTRL, {4'b0010, nv});
		write_reg(NOISE_PERIOD, {1'(rnd(2)), 3'b000, 4'(rnd(8))});
		write_reg(NOISE_LEN, {5'd1, 3'b000});
		repeat (4000) begin
			@(negedge sys_clk);
			#10;
			if (out == 8'(pv))
				seen_p = 1;
			else if (out == 8'(nv))
				seen_n = 1;
			else if (out != 8'h00 && out != 8'(pv) + 8'(nv))
				check("out", out, 8'(pv) + 8'(nv));
		end
		if (!seen_p || !seen_n) begin
			$display("single channel levels not both seen, pulse %0d noise %0d", seen_p, seen_n);
			errors++;
		end
		write_reg(STATUS, 8'h00);
		end_test("test 3 mixer output");

		// 4: frame interrupt timing and clear on status read
		write_reg(FRAME, 8'h00);
		ref_cyc = cycle;
		read_status(st);
		while (!irq && cycle < ref_cyc + SEQ4 + 50)
			@(negedge sys_clk);
		if (!irq || cycle < ref_cyc + SEQ4 - 8 || cycle > ref_cyc + SEQ4 + 8) begin
			$display("irq rose at cycle %0d, expected near %0d", cycle, ref_cyc + SEQ4);
			errors++;
		end
		read_status(st);
		check("rdata", st, 8'h40);
		#10 check("irq", {7'd0, irq}, 8'h00);
		end_test("test 4 frame interrupt");

		// 5: inhibit holds irq low, and setting it clears a pending irq
		write_reg(FRAME, 8'h40);
		ref_cyc = cycle;
		while (cycle < ref_cyc + 2 * SEQ4 + 100) begin
			@(negedge sys_clk);
			#10;
			if (irq) begin
				$display("irq rose with inhibit set at cycle %0d", cycle);
				errors++;
				break;
			end
		end
		write_reg(FRAME, 8'h00);
		ref_cyc = cycle;
		while (!irq && cycle < ref_cyc + SEQ4 + 50)
			@(negedge sys_clk);
		if (!irq) begin
			$display("irq did not rise before the inhibit check");
			errors++;
		end
		write_reg(FRAME, 8'h40);
		@(negedge sys_clk);
		#10 check("irq", {7'd0, irq}, 8'h00);
		end_test("test 5 inhibit");

		// 6: halt holds the noise length, release lets it count down
		write_reg(FRAME, 8'h00);
		ref_cyc = cycle;
		write_reg(STATUS, 8'h02);
		write_reg(NOISE_CTRL, {4'b0010, nv});
		write_reg(NOISE_LEN, {5'd3, 3'b000});  // length 2
		while (cycle < ref_cyc + half_at(3) + 200) begin
			read_status(st);
			if (!st[1]) begin
				$display("noise act dropped while halted at cycle %0d", cycle);
				errors++;
				break;
			end
		end
		write_reg(NOISE_CTRL, {4'b0000, nv});
		expect_fall(1, ref_cyc + half_at(5), "noise act");
		end_test("test 6 noise halt");

		$display("tests passed %0d failed %0d", n_pass, n_fail);
		if (n_fail == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
apu_pkg.sv
apu_frame.sv
apu_pulse.sv
apu_noise.sv
apu_mixer.sv
apu.sv
tb_apu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the apu testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_apu -f list.f -o sim_apu \
	> build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/sim_apu > sim.log 2>&1 || true
cat sim.log

grep -q "Test failed" sim.log && exit 1
grep -q "Test completed successfully" sim.log || exit 1
exit 0
